/* src/npa_defs.svh */
// geometry and width macros for the EVA to NPA request path
// coordinate, pod, vcache and credit parameters

`ifndef NPA_DEFS_SVH
`define NPA_DEFS_SVH

////////////////////////////////////////
// address widths
////////////////////////////////////////
`define EVA_WIDTH           32  // byte effective address
`define EPA_WIDTH           28  // word address inside the destination
`define DATA_WIDTH          32  // store data

////////////////////////////////////////
// mesh geometry
////////////////////////////////////////
`define X_CORD_WIDTH        7   // global x coordinate
`define Y_CORD_WIDTH        7   // global y coordinate
`define POD_X_WIDTH         3   // high bits of x
`define POD_Y_WIDTH         4   // high bits of y
`define X_SUBCORD_WIDTH     4   // low bits of x, position inside the pod
`define Y_SUBCORD_WIDTH     3   // low bits of y, position inside the pod

////////////////////////////////////////
// vcache striping
////////////////////////////////////////
`define VCACHE_ROWS         2   // per side of a pod
`define VCACHE_BLOCK_WORDS  8   // words per cache line

////////////////////////////////////////
// network flow control
////////////////////////////////////////
`define NET_CREDITS         4   // packets allowed in flight

`endif

/* src/npa_pkg.sv */
// opcode and address class types shared by the request path

package npa_pkg;

  ////////////////////////////////////////
  // request opcode
  ////////////////////////////////////////
  // carried unchanged from the core to the packet
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } req_op_e;

  ////////////////////////////////////////
  // address class
  ////////////////////////////////////////
  // local   : EVA below 0x1000, the tile's own data memory
  // global  : EVA[31:30] == 2'b01, tile space anywhere in the mesh
  // dram    : EVA[31] set, striped over the vcache rows
  // illegal : anything else, dropped by the launcher
  typedef enum logic [1:0] {
    class_local   = 2'b00,
    class_global  = 2'b01,
    class_dram    = 2'b10,
    class_illegal = 2'b11
  } addr_class_e;

endpackage

/* src/dram_hash.sv */
// DRAM hash from EVA and home pod to vcache coordinates and word address
// lines are striped over north and south vcache rows

`timescale 1ns/1ps
`include "npa_defs.svh"

module dram_hash (
  input  logic [`EVA_WIDTH-1:0]    eva_i,     // byte address, bit 31 set
  input  logic [`POD_X_WIDTH-1:0]  pod_x_i,   // home pod
  input  logic [`POD_Y_WIDTH-1:0]  pod_y_i,
  output logic [`X_CORD_WIDTH-1:0] x_cord_o,
  output logic [`Y_CORD_WIDTH-1:0] y_cord_o,
  output logic [`EPA_WIDTH-1:0]    epa_o      // word address in the vcache
);

  ////////////////////////////////////////
  // EVA field layout
  ////////////////////////////////////////
  localparam int offset_w_lp  = $clog2(`VCACHE_BLOCK_WORDS);  // word in line
  localparam int row_id_w_lp  = $clog2(2 * `VCACHE_ROWS);     // north and south rows
  localparam int index_w_lp   = `EVA_WIDTH - 1 - 2 - offset_w_lp - `X_SUBCORD_WIDTH
                                - row_id_w_lp;
  localparam int epa_pad_w_lp = `EPA_WIDTH - index_w_lp - offset_w_lp;
  localparam int x_sub_lsb_lp = 2 + offset_w_lp;
  localparam int row_lsb_lp   = x_sub_lsb_lp + `X_SUBCORD_WIDTH;
  localparam int index_lsb_lp = row_lsb_lp + row_id_w_lp;

  logic [offset_w_lp-1:0]       word_offset;
  logic [`X_SUBCORD_WIDTH-1:0]  x_subcord;
  logic [row_id_w_lp-1:0]       row_id;
  logic [index_w_lp-1:0]        dram_index;
  logic [`Y_SUBCORD_WIDTH-1:0]  y_subcord;
  logic [`POD_Y_WIDTH-1:0]      dram_pod_y;

  assign word_offset = eva_i[2 +: offset_w_lp];
  assign x_subcord   = eva_i[x_sub_lsb_lp +: `X_SUBCORD_WIDTH];
  assign row_id      = eva_i[row_lsb_lp +: row_id_w_lp];
  assign dram_index  = eva_i[index_lsb_lp +: index_w_lp];

  // row bit 0 picks the side; the pod row wraps around the mesh
  assign dram_pod_y = row_id[0] ? `POD_Y_WIDTH'(pod_y_i + 1'b1)  // south
                                : `POD_Y_WIDTH'(pod_y_i - 1'b1); // north

  ////////////////////////////////////////
  // y position inside the pod
  ////////////////////////////////////////
  if (`VCACHE_ROWS == 1) begin : g_one_row
    assign y_subcord = {`Y_SUBCORD_WIDTH{~row_id[0]}};  // edge row of the pod
  end else begin : g_multi_row
    // north rows count down from the pod edge, south rows count up
    assign y_subcord = {
      {(`Y_SUBCORD_WIDTH + 1 - row_id_w_lp){~row_id[0]}},
      (row_id[0] ? row_id[row_id_w_lp-1:1] : ~row_id[row_id_w_lp-1:1])
    };
  end

  ////////////////////////////////////////
  // network physical address
  ////////////////////////////////////////
  assign x_cord_o = {pod_x_i, x_subcord};
  assign y_cord_o = {dram_pod_y, y_subcord};
  assign epa_o    = {{epa_pad_w_lp{1'b0}}, dram_index, word_offset};

endmodule

/* src/eva_decode.sv */
// EVA classifier and NPA mapping for local, global and DRAM addresses
// DRAM addresses go through the vcache hash

`timescale 1ns/1ps
`include "npa_defs.svh"

module eva_decode import npa_pkg::*; (
  input  logic [`EVA_WIDTH-1:0]    req_addr_i,
  input  logic [`X_CORD_WIDTH-1:0] my_x_i,      // own tile position
  input  logic [`Y_CORD_WIDTH-1:0] my_y_i,
  output addr_class_e              class_o,
  output logic [`X_CORD_WIDTH-1:0] x_cord_o,
  output logic [`Y_CORD_WIDTH-1:0] y_cord_o,
  output logic [`EPA_WIDTH-1:0]    epa_o
);

  localparam int local_addr_w_lp = 12;  // local memory is 4 KB
  localparam int local_epa_w_lp  = local_addr_w_lp - 2;
  localparam int glob_epa_w_lp   = 14;  // EVA[15:2]
  localparam int glob_y_lsb_lp   = 16;
  localparam int glob_x_lsb_lp   = glob_y_lsb_lp + `Y_CORD_WIDTH;

  addr_class_e                addr_class;
  logic [`POD_X_WIDTH-1:0]    pod_x;
  logic [`POD_Y_WIDTH-1:0]    pod_y;
  logic [`X_CORD_WIDTH-1:0]   dram_x;
  logic [`Y_CORD_WIDTH-1:0]   dram_y;
  logic [`EPA_WIDTH-1:0]      dram_epa;

  // the home pod is the high part of our own coordinates
  assign pod_x = my_x_i[`X_CORD_WIDTH-1 -: `POD_X_WIDTH];
  assign pod_y = my_y_i[`Y_CORD_WIDTH-1 -: `POD_Y_WIDTH];

  ////////////////////////////////////////
  // address class
  ////////////////////////////////////////
  always_comb begin
    if (req_addr_i[`EVA_WIDTH-1:local_addr_w_lp] == '0) begin
      addr_class = class_local;
    end else if (req_addr_i[`EVA_WIDTH-1]) begin
      addr_class = class_dram;
    end else if (req_addr_i[`EVA_WIDTH-2]) begin
      addr_class = class_global;                // top bits 01
    end else begin
      addr_class = class_illegal;               // top bits 00 above local memory
    end
  end

  assign class_o = addr_class;

  dram_hash dram_hash_inst (
    .eva_i    (req_addr_i),
    .pod_x_i  (pod_x),
    .pod_y_i  (pod_y),
    .x_cord_o (dram_x),
    .y_cord_o (dram_y),
    .epa_o    (dram_epa)
  );

  ////////////////////////////////////////
  // NPA select
  ////////////////////////////////////////
  always_comb begin
    case (addr_class)
      class_local: begin
        x_cord_o = my_x_i;
        y_cord_o = my_y_i;
        epa_o    = {{(`EPA_WIDTH - local_epa_w_lp){1'b0}},
                    req_addr_i[local_addr_w_lp-1:2]};
      end
      class_global: begin
        x_cord_o = req_addr_i[glob_x_lsb_lp +: `X_CORD_WIDTH];
        y_cord_o = req_addr_i[glob_y_lsb_lp +: `Y_CORD_WIDTH];
        epa_o    = {{(`EPA_WIDTH - glob_epa_w_lp){1'b0}},
                    req_addr_i[glob_epa_w_lp+1:2]};
      end
      class_dram: begin
        x_cord_o = dram_x;
        y_cord_o = dram_y;
        epa_o    = dram_epa;
      end
      default: begin                            // illegal, nothing to send
        x_cord_o = '0;
        y_cord_o = '0;
        epa_o    = '0;
      end
    endcase
  end

endmodule

/* src/req_launcher.sv */
// request launcher with network credit counter and packet output register
// illegal requests are dropped and flagged for one cycle

`timescale 1ns/1ps
`include "npa_defs.svh"

module req_launcher import npa_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // core side
  input  logic                     req_v_i,
  input  req_op_e                  req_op_i,
  input  logic [`DATA_WIDTH-1:0]   req_data_i,
  output logic                     req_ready_o,
  // from the decoder
  input  addr_class_e              class_i,
  input  logic [`X_CORD_WIDTH-1:0] x_cord_i,
  input  logic [`Y_CORD_WIDTH-1:0] y_cord_i,
  input  logic [`EPA_WIDTH-1:0]    epa_i,
  // network side
  input  logic                     credit_return_i,
  output logic                     pkt_v_o,
  output req_op_e                  pkt_op_o,
  output logic [`X_CORD_WIDTH-1:0] pkt_x_o,
  output logic [`Y_CORD_WIDTH-1:0] pkt_y_o,
  output logic [`EPA_WIDTH-1:0]    pkt_epa_o,
  output logic [`DATA_WIDTH-1:0]   pkt_data_o,
  output logic                     error_o
);

  localparam int credit_w_lp = $clog2(`NET_CREDITS + 1);
  localparam logic [credit_w_lp-1:0] credit_max_lp = credit_w_lp'(`NET_CREDITS);

  logic [credit_w_lp-1:0] credit_cnt;
  logic                   accept;
  logic                   legal_accept;
  logic                   illegal_accept;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////
  assign req_ready_o    = (credit_cnt != '0);   // stall the core when out of credits
  assign accept         = req_v_i & req_ready_o;
  assign legal_accept   = accept & (class_i != class_illegal);
  assign illegal_accept = accept & (class_i == class_illegal);

  ////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt <= credit_max_lp;
    end else begin
      case ({legal_accept, credit_return_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // packet launched
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // credit back from network
        default: credit_cnt <= credit_cnt;         // none or both
      endcase
    end
  end

  ////////////////////////////////////////
  // packet register
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pkt_v_o <= 1'b0;
      error_o <= 1'b0;
    end else begin
      pkt_v_o <= legal_accept;                  // one cycle per accepted request
      error_o <= illegal_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (legal_accept) begin
      pkt_op_o   <= req_op_i;
      pkt_x_o    <= x_cord_i;
      pkt_y_o    <= y_cord_i;
      pkt_epa_o  <= epa_i;
      pkt_data_o <= req_data_i;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // an underflow would wrap past the maximum, so one check covers both bounds
  a_credit_bounds: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt <= credit_max_lp
  ) else $error("credit count out of range");

  // the network may only return credits for packets it holds
  a_no_spare_return: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (credit_return_i && !legal_accept) |-> (credit_cnt != credit_max_lp)
  ) else $error("credit returned with none outstanding");

  // each launch uses up one of the credits counted here
  a_launch_has_credit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_o |-> (($past(credit_cnt) != '0) &&
                 (credit_cnt == $past(credit_cnt) - 1'b1 + $past(credit_return_i)))
  ) else $error("packet launched without a credit");

  // an illegal request neither launches a packet nor takes a credit
  a_err_pkt_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    error_o |-> (!pkt_v_o &&
                 (credit_cnt == $past(credit_cnt) + $past(credit_return_i)))
  ) else $error("error pulse with a packet or a credit taken");

endmodule

/* src/eva_to_npa_top.sv */
// top level of the request address path, decoder plus launcher

`timescale 1ns/1ps
`include "npa_defs.svh"

module eva_to_npa_top import npa_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // core side
  input  logic                     req_v_i,
  input  req_op_e                  req_op_i,
  input  logic [`EVA_WIDTH-1:0]    req_addr_i,
  input  logic [`DATA_WIDTH-1:0]   req_data_i,
  output logic                     req_ready_o,
  // own position
  input  logic [`X_CORD_WIDTH-1:0] my_x_i,
  input  logic [`Y_CORD_WIDTH-1:0] my_y_i,
  // network side
  input  logic                     credit_return_i,
  output logic                     pkt_v_o,
  output req_op_e                  pkt_op_o,
  output logic [`X_CORD_WIDTH-1:0] pkt_x_o,
  output logic [`Y_CORD_WIDTH-1:0] pkt_y_o,
  output logic [`EPA_WIDTH-1:0]    pkt_epa_o,
  output logic [`DATA_WIDTH-1:0]   pkt_data_o,
  output logic                     error_o
);

  addr_class_e                addr_class;   // decoder to launcher
  logic [`X_CORD_WIDTH-1:0]   npa_x;
  logic [`Y_CORD_WIDTH-1:0]   npa_y;
  logic [`EPA_WIDTH-1:0]      npa_epa;

  eva_decode eva_decode_inst (
    .req_addr_i (req_addr_i),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .class_o    (addr_class),
    .x_cord_o   (npa_x),
    .y_cord_o   (npa_y),
    .epa_o      (npa_epa)
  );

  req_launcher req_launcher_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_v_i         (req_v_i),
    .req_op_i        (req_op_i),
    .req_data_i      (req_data_i),
    .req_ready_o     (req_ready_o),
    .class_i         (addr_class),
    .x_cord_i        (npa_x),
    .y_cord_i        (npa_y),
    .epa_i           (npa_epa),
    .credit_return_i (credit_return_i),
    .pkt_v_o         (pkt_v_o),
    .pkt_op_o        (pkt_op_o),
    .pkt_x_o         (pkt_x_o),
    .pkt_y_o         (pkt_y_o),
    .pkt_epa_o       (pkt_epa_o),
    .pkt_data_o      (pkt_data_o),
    .error_o         (error_o)
  );

endmodule

/* tests/clk_gen.sv */
// free running testbench clock

`timescale 1ns/1ps

module clk_gen #(
  parameter int period_p = 20  // ns
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(period_p / 2) clk_o = ~clk_o;

endmodule

/* tests/eva_to_npa_tb.sv */
// testbench for the EVA to NPA request path
// golden vectors with random credit returns, then a credit exhaustion phase

`timescale 1ns/1ps
`include "npa_defs.svh"

module eva_to_npa_tb import npa_pkg::*; ();

  localparam int num_vec_lp     = 14;
  localparam int fields_lp      = 9;
  localparam int clk_period_lp  = 20;
  localparam int timeout_cyc_lp = 200 * (2 * num_vec_lp + 4);  // both phases
  // word positions inside one golden vector
  localparam int f_op_lp        = 0;
  localparam int f_eva_lp       = 1;
  localparam int f_data_lp      = 2;
  localparam int f_myx_lp       = 3;
  localparam int f_myy_lp       = 4;
  localparam int f_class_lp     = 5;
  localparam int f_x_lp         = 6;
  localparam int f_y_lp         = 7;
  localparam int f_epa_lp       = 8;

  logic                     clk;
  logic                     rst_n;
  logic                     req_v;
  req_op_e                  req_op;
  logic [`EVA_WIDTH-1:0]    req_addr;
  logic [`DATA_WIDTH-1:0]   req_data;
  logic                     req_ready;
  logic [`X_CORD_WIDTH-1:0] my_x;
  logic [`Y_CORD_WIDTH-1:0] my_y;
  logic                     credit_return = 1'b0;
  logic                     pkt_v;
  req_op_e                  pkt_op;
  logic [`X_CORD_WIDTH-1:0] pkt_x;
  logic [`Y_CORD_WIDTH-1:0] pkt_y;
  logic [`EPA_WIDTH-1:0]    pkt_epa;
  logic [`DATA_WIDTH-1:0]   pkt_data;
  logic                     err;

  logic [31:0] gold_mem [0:num_vec_lp*fields_lp-1];
  int          exp_q[$];      // vector index per accepted request
  int          outstanding;   // packets in the network with no credit back yet
  int          release_cnt;   // credits handed back while holding
  bit          hold_credits;

  clk_gen #(.period_p(clk_period_lp)) clk_gen_inst (.clk_o(clk));

  eva_to_npa_top eva_to_npa_top_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .req_v_i         (req_v),
    .req_op_i        (req_op),
    .req_addr_i      (req_addr),
    .req_data_i      (req_data),
    .req_ready_o     (req_ready),
    .my_x_i          (my_x),
    .my_y_i          (my_y),
    .credit_return_i (credit_return),
    .pkt_v_o         (pkt_v),
    .pkt_op_o        (pkt_op),
    .pkt_x_o         (pkt_x),
    .pkt_y_o         (pkt_y),
    .pkt_epa_o       (pkt_epa),
    .pkt_data_o      (pkt_data),
    .error_o         (err)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [31:0] golden_field(input int idx, input int fld);
    return gold_mem[idx * fields_lp + fld];
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch at %0t ns: %s got %h expected %h",
                             $time, name, got, exp));
    end
  endtask

  // called on a rising edge, drives one request 1 ns later
  task automatic drive_vec(input int idx);
    logic [31:0] op_word;
    op_word = golden_field(idx, f_op_lp);
    #1;
    req_v    = 1'b1;
    req_op   = req_op_e'(op_word[0]);
    req_addr = golden_field(idx, f_eva_lp);
    req_data = golden_field(idx, f_data_lp);
    my_x     = `X_CORD_WIDTH'(golden_field(idx, f_myx_lp));
    my_y     = `Y_CORD_WIDTH'(golden_field(idx, f_myy_lp));
  endtask

  // returns on the edge that takes the request
  task automatic wait_accept(input int idx);
    logic rdy;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = req_ready;
      @(posedge clk);
    end
    exp_q.push_back(idx);
  endtask

  task automatic send_vec(input int idx);
    drive_vec(idx);
    wait_accept(idx);
  endtask

  task automatic idle_req();
    #1 req_v = 1'b0;
    @(posedge clk);
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || outstanding != 0) @(negedge clk);
    @(posedge clk);
  endtask

  ////////////////////////////////////////
  // network model, credits come back after random gaps
  ////////////////////////////////////////
  always @(posedge clk) begin
    #1;
    credit_return = 1'b0;
    if (rst_n && outstanding > 0) begin
      if (release_cnt > 0) begin
        credit_return = 1'b1;
        release_cnt   = release_cnt - 1;
        outstanding   = outstanding - 1;
      end else if (!hold_credits && ($urandom % 3 != 0)) begin
        credit_return = 1'b1;
        outstanding   = outstanding - 1;
      end
    end
  end

  ////////////////////////////////////////
  // packet and error monitor
  ////////////////////////////////////////
  always @(negedge clk) begin : monitor
    int          idx;
    logic [31:0] exp_class;
    if (rst_n && (pkt_v || err)) begin
      if (pkt_v && err) report_error("packet valid and error raised in the same cycle");
      if (exp_q.size() == 0) report_error("output seen with no request accepted");
      idx       = exp_q.pop_front();
      exp_class = golden_field(idx, f_class_lp);
      if (err) begin
        if (exp_class != class_illegal) report_error("error raised for a legal request");
        check_val("req_ready_o", req_ready, 1'b1);   // illegal uses no credit
      end else begin
        if (exp_class == class_illegal) report_error("packet launched for an illegal request");
        check_val("pkt_op_o", pkt_op, golden_field(idx, f_op_lp));
        check_val("pkt_x_o", pkt_x, golden_field(idx, f_x_lp));
        check_val("pkt_y_o", pkt_y, golden_field(idx, f_y_lp));
        check_val("pkt_epa_o", pkt_epa, golden_field(idx, f_epa_lp));
        check_val("pkt_data_o", pkt_data, golden_field(idx, f_data_lp));
        outstanding = outstanding + 1;
      end
    end
  end

  initial begin : watchdog
    #(timeout_cyc_lp * clk_period_lp);
    report_error("timeout: the DUT stopped taking requests or sending packets");
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin : main
    int legal_q[$];
    int illegal_q[$];
    void'($urandom(32'h8951));
    rst_n        = 1'b0;
    req_v        = 1'b0;
    req_op       = op_load;
    req_addr     = '0;
    req_data     = '0;
    my_x         = '0;
    my_y         = '0;
    outstanding  = 0;
    release_cnt  = 0;
    hold_credits = 1'b0;
    $readmemh("tests/npa_golden.hex", gold_mem);
    for (int i = 0; i < num_vec_lp * fields_lp; i++) begin
      if ((^gold_mem[i]) === 1'bx) report_error("golden vector file is incomplete");
    end
    for (int i = 0; i < num_vec_lp; i++) begin
      if (golden_field(i, f_class_lp) != class_illegal) begin
        legal_q.push_back(i);
      end else begin
        illegal_q.push_back(i);
      end
    end

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_val("pkt_v_o", pkt_v, 1'b0);
    check_val("error_o", err, 1'b0);
    check_val("req_ready_o", req_ready, 1'b1);
    @(posedge clk);

    // all vectors back to back, credits returned at random
    for (int i = 0; i < num_vec_lp; i++) send_vec(i);
    idle_req();
    drain();

    // no credits back, the fifth request has to stall
    hold_credits = 1'b1;
    for (int i = 0; i < `NET_CREDITS - 1; i++) send_vec(legal_q[i]);
    send_vec(illegal_q[0]);                       // last credit stays free
    send_vec(legal_q[`NET_CREDITS-1]);
    @(negedge clk);
    check_val("req_ready_o", req_ready, 1'b0);
    for (int i = `NET_CREDITS; i < `NET_CREDITS + 2; i++) begin
      @(posedge clk);
      drive_vec(legal_q[i]);
      repeat (4) begin
        @(negedge clk);
        check_val("req_ready_o", req_ready, 1'b0);
      end
      release_cnt = 1;                            // exactly one credit back
      wait_accept(legal_q[i]);
      @(negedge clk);
      check_val("req_ready_o", req_ready, 1'b0);
    end
    @(posedge clk);
    idle_req();
    hold_credits = 1'b0;
    drain();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/npa_pkg.sv
src/dram_hash.sv
src/eva_decode.sv
src/req_launcher.sv
src/eva_to_npa_top.sv
tests/clk_gen.sv
tests/eva_to_npa_tb.sv

/* tests/npa_golden.hex */
// op eva data my_x my_y | expected class x y epa
// class 0 local, 1 global, 2 dram, 3 illegal
0 00000ffc 00000000 25 2a 0 25 2a 00003ff
1 49acabc4 deadbeef 25 2a 1 13 2c 0002af1
1 891a2b54 01234567 25 2a 2 2a 30 0091a2d
1 00001000 55aa55aa 25 2a 3 00 00 0000000
0 80000e60 00000000 25 2a 2 23 31 0000008
1 00000010 cafef00d 7f 7d 0 7f 7d 0000004
0 fffff9ff 00000000 25 2a 2 2f 27 07fffff
1 7ffffffc ffffffff 25 2a 1 7f 7f 0003fff
1 8055e404 13579bdf 25 2a 2 20 26 00055e1
0 3fffffff 00000000 25 2a 3 00 00 0000000
1 a00002c8 2468ace0 5c 7d 2 56 00 0200002
0 80003d2c 00000000 7f 03 2 79 7e 000003b
0 40000000 00000000 5c 7d 1 00 00 0000000
1 80000620 89abcdef 7f 03 2 71 09 0000000
